// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_graph_ingest
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
verilog/graph_pkg.sv
verilog/edge_if.sv
verilog/input_decoder.sv
verilog/edge_fifo.sv
verilog/edge_tally.sv
verilog/graph_ingest_top.sv
tests/tb_graph_ingest.sv

// File: tests/tb_graph_ingest.sv
`timescale 1ns/1ps

module tb_graph_ingest;

    logic                              clk;
    logic                              arst_n;
    logic                              byte_valid;
    logic [7:0]                        byte_data;
    graph_pkg::node_t                  target_node;
    graph_pkg::node_t                  query_node;
    logic                              done;
    logic [graph_pkg::count_width-1:0] edge_count;
    logic [graph_pkg::count_width-1:0] target_in_degree;
    logic [graph_pkg::count_width-1:0] query_out_degree;
    logic                              overflow;

    // expected statistics of the current file
    graph_pkg::node_t tgt_code;
    graph_pkg::node_t qry_code;
    int               exp_edges;
    int               exp_in;
    int               exp_out;
    int               checks;
    int               errors;
    int               timeouts;
    logic [31:0]      rng;
    string            dst_q[$]; // destinations of the next line

    graph_ingest_top i_graph_ingest_top (.*);

    always #20 clk = ~clk;

    // first letter in the low bits, each letter as offset from 'a'
    function automatic graph_pkg::node_t encode_name(input string s);
        graph_pkg::node_t n;
        logic [7:0]       ch;
        n = '0;
        for (int i = 0; i < graph_pkg::node_chars; i++) begin
            ch = s[i];
            n[i*graph_pkg::node_bin_bits +: graph_pkg::node_bin_bits] =
                5'(ch - graph_pkg::a_char);
        end
        return n;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // small alphabet a..d so that names repeat
    function automatic string rand_name();
        logic [7:0] c [3];
        for (int i = 0; i < 3; i++) begin
            rng  = xorshift(rng);
            c[i] = graph_pkg::a_char + {6'b0, rng[5:4]};
        end
        return $sformatf("%c%c%c", c[0], c[1], c[2]);
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n     <= 1'b0;
        byte_valid <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic start_file(input string t, input string q);
        tgt_code  = encode_name(t);
        qry_code  = encode_name(q);
        exp_edges = 0;
        exp_in    = 0;
        exp_out   = 0;
        @(posedge clk);
        target_node <= tgt_code;
        query_node  <= qry_code;
        apply_reset();
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            @(posedge clk);
            byte_valid <= 1'b1;
            byte_data  <= s[i];
        end
        @(posedge clk);
        byte_valid <= 1'b0;
    endtask

    // sends "src: d0 d1 ..." plus line feed and updates the model
    task automatic send_line(input string src);
        string line;
        line = $sformatf("%s%c", src, graph_pkg::colon_char);
        foreach (dst_q[i]) begin
            line = $sformatf("%s%c%s", line, graph_pkg::space_char, dst_q[i]);
            exp_edges++;
            if (encode_name(dst_q[i]) == tgt_code)
                exp_in++;
            if (encode_name(src) == qry_code)
                exp_out++;
        end
        send_text($sformatf("%s%c", line, graph_pkg::lf_char));
        dst_q.delete();
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (done) else begin
            timeouts++;
            $display("timeout: done did not rise within %0d cycles", limit);
        end
    endtask

    task automatic check_all();
        check_value("edge_count", edge_count, exp_edges);
        check_value("target_in_degree", target_in_degree, exp_in);
        check_value("query_out_degree", query_out_degree, exp_out);
        check_value("overflow", overflow, 0);
    endtask

    task automatic end_file();
        send_text("."); // stray byte on the source side marks eof
        wait_done(1000);
        check_all();
    endtask

    task automatic single_line_counts();
        start_file("ccc", "aaa");
        dst_q = '{"bbb", "ccc"};
        send_line("aaa");
        end_file();
        check_value("edge_count", edge_count, 2); // fixed by the text itself
    endtask

    task automatic repeated_target();
        start_file("kkk", "mmm");
        dst_q = '{"kkk", "xyz"};
        send_line("abc");
        dst_q = '{"qrs", "kkk", "tuv"};
        send_line("mmm");
        dst_q = '{"kkk"};
        send_line("xyz");
        end_file();
    endtask

    task automatic letter_order_match();
        start_file("abz", "zba");
        dst_q = '{"abz", "baz"};
        send_line("zba");
        dst_q = '{"zba", "abz", "azb"};
        send_line("baz");
        end_file();
    endtask

    task automatic random_file(input int lines);
        int n;
        for (int l = 0; l < lines; l++) begin
            rng = xorshift(rng);
            n   = 1 + int'(rng[9:8]);
            for (int d = 0; d < n; d++)
                dst_q.push_back(rand_name());
            send_line(rand_name());
        end
        end_file();
    endtask

    task automatic random_text();
        start_file("abc", "bca");
        random_file(20);
    endtask

    task automatic reset_between_files();
        start_file("aab", "bba");
        random_file(6);
        apply_reset();
        @(negedge clk);
        check_value("done", done, 0);
        check_value("edge_count", edge_count, 0);
        check_value("target_in_degree", target_in_degree, 0);
        check_value("query_out_degree", query_out_degree, 0);
        start_file("dca", "acd"); // second file, fresh model
        random_file(8);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        byte_valid  = 1'b0;
        byte_data   = 8'h00;
        target_node = '0;
        query_node  = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        rng         = 32'h80a6;
        single_line_counts();
        repeated_target();
        letter_order_match();
        random_text();
        reset_between_files();
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog/edge_fifo.sv
`timescale 1ns/1ps

module edge_fifo #(
    parameter type payload_t = graph_pkg::edge_item_t
) (
    input  logic       clk,
    input  logic       arst_n,
    edge_push_if.buffer wr,
    edge_hs_if.source   rd
);

    typedef enum logic [1:0] {
        st_idle, // nothing presented
        st_req,  // req high, waiting for ack
        st_wait  // req dropped, waiting for ack low
    } rd_state_t;

    payload_t                                  mem [graph_pkg::fifo_depth];
    logic [$clog2(graph_pkg::fifo_depth)-1:0]  wr_ptr;
    logic [$clog2(graph_pkg::fifo_depth)-1:0]  rd_ptr;
    logic [$clog2(graph_pkg::fifo_depth):0]    count;
    logic                                      push_en;
    logic                                      pop_en;
    logic                                      load;
    rd_state_t                                 state;

    assign wr.full = (count == graph_pkg::fifo_depth);
    assign push_en = wr.valid && !wr.full;
    assign pop_en  = (state == st_req) && rd.ack;
    // present the next head item when idle, or right after ack went low
    assign load    = (count != 0) && ((state == st_idle) || (state == st_wait && !rd.ack));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            wr.overflow <= 1'b0;
            rd.req      <= 1'b0;
            state       <= st_idle;
        end else begin
            if (push_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (wr.valid && wr.full)
                wr.overflow <= 1'b1; // item dropped
            count <= count + push_en - pop_en;

            case (state)
                st_idle, st_wait: begin
                    if (load) begin
                        rd.req <= 1'b1;
                        state  <= st_req;
                    end else if (state == st_wait && !rd.ack) begin
                        state <= st_idle;
                    end
                end
                st_req: begin
                    if (rd.ack) begin
                        rd.req <= 1'b0;
                        rd_ptr <= rd_ptr + 1'b1; // pop head
                        state  <= st_wait;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_en)
            mem[wr_ptr] <= wr.item;
        if (load)
            rd.item <= mem[rd_ptr];
    end

    a_item_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd.req |=> !rd.req || $stable(rd.item)
    ) else $error("item changed while req high");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= graph_pkg::fifo_depth
    ) else $error("occupancy above depth");

endmodule

// File: verilog/edge_if.sv
`timescale 1ns/1ps

// producer writes on every valid cycle, full only tells it the item is lost
interface edge_push_if #(
    parameter type payload_t = graph_pkg::edge_item_t
);

    logic     valid;
    payload_t item;
    logic     full;
    logic     overflow; // sticky until reset

    modport producer (
        output valid,
        output item,
        input  full,
        input  overflow
    );

    modport buffer (
        input  valid,
        input  item,
        output full,
        output overflow
    );

endinterface

// four-phase req/ack, item held stable while req is high
interface edge_hs_if #(
    parameter type payload_t = graph_pkg::edge_item_t
);

    logic     req;
    payload_t item;
    logic     ack;

    modport source (output req, output item, input ack);
    modport sink (input req, input item, output ack);

endinterface

// File: verilog/edge_tally.sv
`timescale 1ns/1ps

module edge_tally (
    input  logic                              clk,
    input  logic                              arst_n,
    input  graph_pkg::node_t                  target_node,
    input  graph_pkg::node_t                  query_node,
    edge_hs_if.sink                           rd,
    output logic                              done,
    output logic [graph_pkg::count_width-1:0] edge_count,
    output logic [graph_pkg::count_width-1:0] target_in_degree,
    output logic [graph_pkg::count_width-1:0] query_out_degree
);

    logic take; // new item offered and not yet acknowledged
    logic dst_hit;
    logic src_hit;

    assign take    = rd.req && !rd.ack;
    assign dst_hit = (rd.item.dst == target_node);
    assign src_hit = (rd.item.src == query_node);

    // ack follows req one cycle later in both directions
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd.ack <= 1'b0;
        end else if (take) begin
            rd.ack <= 1'b1;
        end else if (!rd.req && rd.ack) begin
            rd.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done             <= 1'b0;
            edge_count       <= '0;
            target_in_degree <= '0;
            query_out_degree <= '0;
        end else if (take) begin
            if (rd.item.eof) begin
                done <= 1'b1; // whole file has passed
            end else begin
                edge_count <= edge_count + 1'b1;
                if (dst_hit)
                    target_in_degree <= target_in_degree + 1'b1;
                if (src_hit)
                    query_out_degree <= query_out_degree + 1'b1;
            end
        end
    end

    // ack may only answer a req seen on the previous edge
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(rd.ack) |-> $past(rd.req)
    ) else $error("ack rose without req");

endmodule

// File: verilog/graph_ingest_top.sv
`timescale 1ns/1ps

module graph_ingest_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              byte_valid,
    input  logic [7:0]                        byte_data,
    input  graph_pkg::node_t                  target_node, // hold for the whole file
    input  graph_pkg::node_t                  query_node,
    output logic                              done,
    output logic [graph_pkg::count_width-1:0] edge_count,
    output logic [graph_pkg::count_width-1:0] target_in_degree,
    output logic [graph_pkg::count_width-1:0] query_out_degree,
    output logic                              overflow
);

    edge_push_if #(.payload_t(graph_pkg::edge_item_t)) push_bus ();
    edge_hs_if #(.payload_t(graph_pkg::edge_item_t)) hs_bus ();

    assign overflow = push_bus.overflow;

    input_decoder i_input_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .push       (push_bus)
    );

    edge_fifo #(.payload_t(graph_pkg::edge_item_t)) i_edge_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (push_bus),
        .rd     (hs_bus)
    );

    edge_tally i_edge_tally (
        .clk              (clk),
        .arst_n           (arst_n),
        .target_node      (target_node),
        .query_node       (query_node),
        .rd               (hs_bus),
        .done             (done),
        .edge_count       (edge_count),
        .target_in_degree (target_in_degree),
        .query_out_degree (query_out_degree)
    );

endmodule

// File: verilog/graph_pkg.sv
package graph_pkg;

    localparam int node_chars    = 3; // letters per node name
    localparam int node_bin_bits = 5; // bits per letter
    localparam int node_width    = node_chars * node_bin_bits;

    // first letter sits in the low bits, each letter stored as offset from 'a'
    typedef logic [node_width-1:0] node_t;

    // ascii codes seen in the text stream
    localparam logic [7:0] a_char     = 8'h61;
    localparam logic [7:0] z_char     = 8'h7a;
    localparam logic [7:0] colon_char = 8'h3a;
    localparam logic [7:0] space_char = 8'h20;
    localparam logic [7:0] lf_char    = 8'h0a;

    // one decoded edge, or the end-of-file marker
    typedef struct packed {
        logic  eof; // src and dst are don't care when set
        node_t src;
        node_t dst;
    } edge_item_t;

    localparam int fifo_depth  = 16; // edge buffer entries
    localparam int count_width = 16; // width of each statistic

endpackage

// File: verilog/input_decoder.sv
`timescale 1ns/1ps

module input_decoder (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        byte_valid,
    input  logic [7:0]  byte_data,
    edge_push_if.producer push
);

    logic                             src_set;     // colon seen on this line
    logic                             prev_letter; // last accepted byte was a letter
    logic                             eof_seen;
    logic                             accept;
    logic                             is_letter;
    logic                             is_colon;
    logic                             is_lf;
    logic [7:0]                       offset;
    logic [graph_pkg::node_bin_bits-1:0] letter;
    graph_pkg::node_t                 src_node;
    graph_pkg::node_t                 dst_node;
    graph_pkg::edge_item_t            next_item;

    function automatic logic char_is_letter(input logic [7:0] c);
        return (c >= graph_pkg::a_char) && (c <= graph_pkg::z_char);
    endfunction

    assign accept    = byte_valid && !eof_seen; // nothing is taken after eof
    assign is_letter = char_is_letter(byte_data);
    assign is_colon  = (byte_data == graph_pkg::colon_char);
    assign is_lf     = (byte_data == graph_pkg::lf_char);
    assign offset    = byte_data - graph_pkg::a_char;
    assign letter    = offset[graph_pkg::node_bin_bits-1:0];

    always_comb begin
        next_item.src = src_node;
        next_item.dst = dst_node;
        next_item.eof = !src_set; // only a stray byte on the lhs gets here with valid
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src_set     <= 1'b0;
            prev_letter <= 1'b0;
            eof_seen    <= 1'b0;
            push.valid  <= 1'b0;
        end else begin
            push.valid <= 1'b0;
            if (accept) begin
                prev_letter <= is_letter;
                if (!src_set) begin
                    if (is_colon) begin
                        src_set <= 1'b1;
                    end else if (!is_letter) begin
                        // stray byte where a source name should start
                        eof_seen   <= 1'b1;
                        push.valid <= 1'b1;
                    end
                end else if (!is_letter) begin
                    if (prev_letter) begin
                        push.valid <= 1'b1; // separator closes a destination
                    end
                    if (is_lf) begin
                        src_set <= 1'b0;
                    end
                end
            end
        end
    end

    // name registers and outgoing item
    always_ff @(posedge clk) begin
        if (accept && is_letter) begin
            if (!src_set) begin
                src_node <= {letter, src_node[graph_pkg::node_width-1:graph_pkg::node_bin_bits]};
            end else begin
                dst_node <= {letter, dst_node[graph_pkg::node_width-1:graph_pkg::node_bin_bits]};
            end
        end
        if (accept && !is_letter) begin
            push.item <= next_item;
        end
    end

    // the byte source must go quiet once the terminating byte was sent
    a_no_byte_after_eof: assert property (
        @(posedge clk) disable iff (!arst_n)
        eof_seen |-> !byte_valid
    ) else $error("byte received after end of file");

endmodule
